//--- Bender.yml
package:
  name: alu_coproc

sources:
  - rtl/alu_pkg.sv
  - rtl/alu_if.sv
  - rtl/alu_div.sv
  - rtl/alu_core.sv
  - rtl/alu_wb_regs.sv
  - rtl/alu_top.sv
  - target: test
    files:
      - test/alu_props.sv
      - test/alu_tb.sv

//--- rtl/alu_core.sv
`timescale 1ns/10ps
// ALU datapath and flag generation at byte, word or long width
module alu_core
    import alu_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic cen,
    alu_if.alu   bus
);

    logic               cx;         // selected carry / fill bit
    logic [2:0]         cc;         // carry out of byte, word, long
    logic               h, c, z, n, p, v, v_as;
    logic               is_sub, a_top, b_top;
    logic [31:0]        rslt;
    logic signed [31:0] prod_s;
    logic [15:0]        div_quot, div_rem;
    logic               div_v;

    alu_div div_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .start    (bus.div_start),
        .sign     (bus.op == DIVS_OP),
        .len      (bus.size != SZ_BYTE),
        .dividend (bus.op0),
        .divisor  (bus.op1[15:0]),
        .quot     (div_quot),
        .rem      (div_rem),
        .busy     (bus.div_busy),
        .v        (div_v)
    );

    assign prod_s = $signed(bus.op0[15:0]) * $signed(bus.op1[15:0]);

    always_comb begin
        case (bus.cx_sel)
            ZERO_CX: cx = 1'b0;
            CIN_CX:  cx = bus.cin;
            COM_CX:  cx = ~bus.cin;
            ONE_CX:  cx = 1'b1;
            SA_CX: begin
                case (bus.size)
                    SZ_BYTE: cx = bus.op2[7];
                    SZ_WORD: cx = bus.op2[15];
                    default: cx = bus.op2[31];
                endcase
            end
            SH_CX:   cx = bus.op2[0];
            default: cx = 1'b0;
        endcase
    end

    always_comb begin
        rslt = bus.op0;
        cc   = {3{cx}};     // logic ops pass the carry bit through
        h    = 1'b0;
        case (bus.op)
            ADD_OP: begin
                {h, rslt[3:0]}       = {1'b0, bus.op0[3:0]} + {1'b0, bus.op1[3:0]} + {4'd0, cx};
                {cc[0], rslt[7:4]}   = {1'b0, bus.op0[7:4]} + {1'b0, bus.op1[7:4]} + {4'd0, h};
                {cc[1], rslt[15:8]}  = {1'b0, bus.op0[15:8]} + {1'b0, bus.op1[15:8]}
                                     + {8'd0, cc[0]};
                {cc[2], rslt[31:16]} = {1'b0, bus.op0[31:16]} + {1'b0, bus.op1[31:16]}
                                     + {16'd0, cc[1]};
            end
            SUB_OP: begin   // carries are borrows here
                {h, rslt[3:0]}       = {1'b0, bus.op0[3:0]} - {1'b0, bus.op1[3:0]} - {4'd0, cx};
                {cc[0], rslt[7:4]}   = {1'b0, bus.op0[7:4]} - {1'b0, bus.op1[7:4]} - {4'd0, h};
                {cc[1], rslt[15:8]}  = {1'b0, bus.op0[15:8]} - {1'b0, bus.op1[15:8]}
                                     - {8'd0, cc[0]};
                {cc[2], rslt[31:16]} = {1'b0, bus.op0[31:16]} - {1'b0, bus.op1[31:16]}
                                     - {16'd0, cc[1]};
            end
            AND_OP:  rslt = bus.op0 & bus.op1;
            OR_OP:   rslt = bus.op0 | bus.op1;
            XOR_OP:  rslt = bus.op0 ^ bus.op1;
            CPL_OP:  rslt[15:0] = ~bus.op0[15:0];
            MUL_OP:  rslt = bus.op0[15:0] * bus.op1[15:0];
            MULS_OP: rslt = prod_s;
            DIV_OP, DIVS_OP: begin
                if (bus.size == SZ_BYTE)
                    rslt = {16'd0, div_rem[7:0], div_quot[7:0]};
                else
                    rslt = {div_rem, div_quot};
            end
            SHL_OP: begin
                {cc[2], rslt} = {bus.op2, cx};
                cc[0] = bus.op2[7];
                cc[1] = bus.op2[15];
            end
            SHR_OP: begin
                {rslt, cc[0]} = {cx, bus.op2};
                if (bus.size == SZ_BYTE) rslt[7] = cx;     // fill at the width's top bit
                if (bus.size == SZ_WORD) rslt[15] = cx;
                cc[2:1] = {2{bus.op2[0]}};
            end
            default: ;
        endcase
    end

    // flags at the selected width
    always_comb begin
        is_sub = bus.op == SUB_OP;
        case (bus.size)
            SZ_BYTE: begin
                c     = cc[0];
                z     = rslt[7:0] == 8'd0;
                n     = rslt[7];
                a_top = bus.op0[7];
                b_top = bus.op1[7];
            end
            SZ_WORD: begin
                c     = cc[1];
                z     = rslt[15:0] == 16'd0;
                n     = rslt[15];
                a_top = bus.op0[15];
                b_top = bus.op1[15];
            end
            default: begin
                c     = cc[2];
                z     = rslt == 32'd0;
                n     = rslt[31];
                a_top = bus.op0[31];
                b_top = bus.op1[31];
            end
        endcase
        p    = (bus.size == SZ_BYTE) ? ~^rslt[7:0] : ~^rslt[15:0];   // even parity
        v_as = (is_sub ? (a_top != b_top) : (a_top == b_top)) && (n != a_top);
        if (bus.op == ADD_OP || is_sub)
            v = v_as;
        else if (is_div(bus.op))
            v = div_v;
        else
            v = 1'b0;
    end

    assign bus.rslt = rslt;

    always_comb begin
        bus.flags         = '0;
        bus.flags[FLAG_C] = c;
        bus.flags[FLAG_N] = n;
        bus.flags[FLAG_V] = v;
        bus.flags[FLAG_P] = p;
        bus.flags[FLAG_H] = h;
        bus.flags[FLAG_Z] = z;
    end

endmodule

//--- rtl/alu_div.sv
`timescale 1ns/10ps
// restoring divider for 16/8 and 32/16 operands, signed or unsigned
module alu_div (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        start,
    input  logic        sign,
    input  logic        len,        // high for 32/16
    input  logic [31:0] dividend,
    input  logic [15:0] divisor,
    output logic [15:0] quot,
    output logic [15:0] rem,
    output logic        busy,
    output logic        v
);

    logic [31:0] a_ext, a_mag;
    logic [15:0] d_ext, d_mag, hi, half;
    logic        a_neg, d_neg;
    logic [15:0] r, q, d;           // partial remainder, dividend/quotient, divisor
    logic [16:0] r_sh;
    logic        ge;
    logic [4:0]  cnt;               // steps left
    logic        neg_q, neg_r;

    // magnitudes at the selected width
    always_comb begin
        a_ext = len ? dividend : {{16{sign & dividend[15]}}, dividend[15:0]};
        d_ext = len ? divisor : {{8{sign & divisor[7]}}, divisor[7:0]};
        a_neg = sign & a_ext[31];
        d_neg = sign & d_ext[15];
        a_mag = a_neg ? -a_ext : a_ext;
        d_mag = d_neg ? -d_ext : d_ext;
        hi    = len ? a_mag[31:16] : {8'd0, a_mag[15:8]};
    end

    assign r_sh = {r, q[15]};
    assign ge   = r_sh >= {1'b0, d};
    assign half = len ? 16'h8000 : 16'h0080;   // smallest magnitude out of signed range
    assign quot = q;
    assign rem  = r;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            cnt  <= '0;
            v    <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= len ? 5'd16 : 5'd8;
            v    <= (d_mag == 16'd0) || (hi >= d_mag);   // quotient too wide
        end else if (busy && cen) begin
            if (cnt != 5'd0) begin
                cnt <= cnt - 5'd1;
            end else begin
                busy <= 1'b0;      // sign fix-up cycle
                if (sign && (neg_q ? (q > half) : (q >= half)))
                    v <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            r     <= hi;
            q     <= len ? a_mag[15:0] : {a_mag[7:0], 8'd0};
            d     <= d_mag;
            neg_q <= a_neg ^ d_neg;
            neg_r <= a_neg;    // remainder follows dividend
        end else if (busy && cen) begin
            if (cnt != 5'd0) begin
                r <= ge ? r_sh[15:0] - d : r_sh[15:0];
                q <= {q[14:0], ge};
            end else begin
                if (neg_q) q <= -q;
                if (neg_r) r <= -r;
            end
        end
    end

endmodule

//--- rtl/alu_if.sv
`timescale 1ns/10ps
// operand, command and result bundle between the register block and the ALU
interface alu_if
    import alu_pkg::*;
();

    logic [31:0] op0;
    logic [31:0] op1;
    logic [31:0] op2;       // shift source
    alu_op_e     op;
    cx_sel_e     cx_sel;
    op_size_e    size;
    logic        cin;
    logic        div_start;  // one cycle pulse
    logic        div_busy;
    logic [31:0] rslt;
    logic [5:0]  flags;

    modport ctrl (output op0, op1, op2, op, cx_sel, size, cin, div_start,
                  input  rslt, flags, div_busy);

    modport alu  (input  op0, op1, op2, op, cx_sel, size, cin, div_start,
                  output rslt, flags, div_busy);

endinterface

//--- rtl/alu_pkg.sv
// ALU coprocessor shared types, register map and command/flag layout
package alu_pkg;

    typedef enum logic [3:0] {
        ADD_OP = 4'd0, SUB_OP = 4'd1, AND_OP = 4'd2, OR_OP = 4'd3,
        XOR_OP = 4'd4, CPL_OP = 4'd5, MUL_OP = 4'd6, MULS_OP = 4'd7,
        DIV_OP = 4'd8, DIVS_OP = 4'd9, SHL_OP = 4'd10, SHR_OP = 4'd11
    } alu_op_e;

    typedef enum logic [2:0] {
        ZERO_CX = 3'd0,
        CIN_CX  = 3'd1,
        COM_CX  = 3'd2,     // inverted cin
        ONE_CX  = 3'd3,
        SA_CX   = 3'd4,     // op2 sign bit, arithmetic shift
        SH_CX   = 3'd5      // op2 bit 0, rotate right
    } cx_sel_e;

    typedef enum logic [1:0] {SZ_BYTE = 2'd0, SZ_WORD = 2'd1, SZ_LONG = 2'd2} op_size_e;

    localparam logic [2:0] REG_OP0    = 3'd0;
    localparam logic [2:0] REG_OP1    = 3'd1;
    localparam logic [2:0] REG_OP2    = 3'd2;
    localparam logic [2:0] REG_CMD    = 3'd3;
    localparam logic [2:0] REG_RESULT = 3'd4;
    localparam logic [2:0] REG_FLAGS  = 3'd5;

    localparam int CMD_OP_LSB = 0;
    localparam int CMD_OP_MSB = 3;
    localparam int CMD_CX_LSB = 4;
    localparam int CMD_CX_MSB = 6;
    localparam int CMD_SZ_LSB = 7;
    localparam int CMD_SZ_MSB = 8;
    localparam int CMD_CIN    = 9;     // also the top bit of the command word

    localparam int FLAG_C = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_V = 2;
    localparam int FLAG_P = 3;
    localparam int FLAG_H = 4;
    localparam int FLAG_Z = 5;

    function automatic logic is_div(alu_op_e op);
        return (op == DIV_OP) || (op == DIVS_OP);
    endfunction

endpackage

//--- rtl/alu_top.sv
`timescale 1ns/10ps
// ALU coprocessor top level with a Wishbone classic slave port
module alu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,        // divider step enable
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    alu_if bus ();

    alu_wb_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .bus      (bus.ctrl)
    );

    alu_core core_i (
        .clk (clk),
        .rst (rst),
        .cen (cen),
        .bus (bus.alu)
    );

endmodule

//--- rtl/alu_wb_regs.sv
`timescale 1ns/10ps
// Wishbone classic register block that sequences ALU commands
module alu_wb_regs
    import alu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [2:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    alu_if.ctrl         bus
);

    typedef enum logic [1:0] {IDLE, EXEC, DIV_WAIT, ACK} state_e;

    state_e      state;
    logic [31:0] op0_r, op1_r, op2_r, result_r;
    logic [9:0]  cmd_r;
    logic [5:0]  flags_r;
    logic        req, cmd_wr;

    assign req    = wb_cyc && wb_stb && !wb_ack;    // new request only
    assign cmd_wr = req && wb_we && (wb_adr == REG_CMD);

    assign bus.op0    = op0_r;
    assign bus.op1    = op1_r;
    assign bus.op2    = op2_r;
    assign bus.op     = alu_op_e'(cmd_r[CMD_OP_MSB:CMD_OP_LSB]);
    assign bus.cx_sel = cx_sel_e'(cmd_r[CMD_CX_MSB:CMD_CX_LSB]);
    assign bus.size   = op_size_e'(cmd_r[CMD_SZ_MSB:CMD_SZ_LSB]);
    assign bus.cin    = cmd_r[CMD_CIN];

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= IDLE;
            wb_ack        <= 1'b0;
            bus.div_start <= 1'b0;
            op0_r         <= '0;
            op1_r         <= '0;
            op2_r         <= '0;
            cmd_r         <= '0;
            result_r      <= '0;
            flags_r       <= '0;
        end else begin
            wb_ack        <= 1'b0;
            bus.div_start <= 1'b0;
            case (state)
                IDLE: if (req) begin
                    if (wb_we && wb_adr == REG_OP0) op0_r <= wb_dat_w;
                    if (wb_we && wb_adr == REG_OP1) op1_r <= wb_dat_w;
                    if (wb_we && wb_adr == REG_OP2) op2_r <= wb_dat_w;
                    if (cmd_wr) cmd_r <= wb_dat_w[CMD_CIN:0];
                    if (cmd_wr && is_div(alu_op_e'(wb_dat_w[CMD_OP_MSB:CMD_OP_LSB]))) begin
                        bus.div_start <= 1'b1;  // ack held until the divider ends
                        state         <= DIV_WAIT;
                    end else begin
                        wb_ack <= 1'b1;
                        if (cmd_wr) state <= EXEC;
                    end
                end
                EXEC: begin     // core output valid, ack high now
                    result_r <= bus.rslt;
                    flags_r  <= bus.flags;
                    state    <= IDLE;
                end
                DIV_WAIT: if (!bus.div_start && !bus.div_busy) begin
                    result_r <= bus.rslt;
                    flags_r  <= bus.flags;
                    wb_ack   <= 1'b1;
                    state    <= ACK;
                end
                default: state <= IDLE;   // ACK
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req && !wb_we) begin
            case (wb_adr)
                REG_OP0:    wb_dat_r <= op0_r;
                REG_OP1:    wb_dat_r <= op1_r;
                REG_OP2:    wb_dat_r <= op2_r;
                REG_CMD:    wb_dat_r <= {22'd0, cmd_r};
                REG_RESULT: wb_dat_r <= result_r;
                REG_FLAGS:  wb_dat_r <= {26'd0, flags_r};
                default:    wb_dat_r <= '0;
            endcase
        end
    end

endmodule

//--- tb.f
rtl/alu_pkg.sv
rtl/alu_if.sv
rtl/alu_div.sv
rtl/alu_core.sv
rtl/alu_wb_regs.sv
rtl/alu_top.sv
test/alu_props.sv
test/alu_tb.sv

//--- test/alu_props.sv
`timescale 1ns/10ps
// Wishbone handshake assertions for the ALU coprocessor slave port
module alu_props (
    input logic clk,
    input logic rst,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
                                   wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack high outside a cyc and stb request");

    ack_single: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack high on two cycles in a row");

    // ack is registered, so it clears one edge into reset
    ack_reset: assert property (@(posedge clk) rst |=> !wb_ack)
        else $error("wb_ack high during reset");

endmodule

bind alu_top alu_props props_i (
    .clk    (clk),
    .rst    (rst),
    .wb_cyc (wb_cyc),
    .wb_stb (wb_stb),
    .wb_ack (wb_ack)
);

//--- test/alu_tb.sv
`timescale 1ns/10ps
// testbench for the ALU coprocessor, runs operation vectors over the Wishbone port
module alu_tb
    import alu_pkg::*;
();

    localparam int NFIELD  = 11;    // words per vector line
    localparam int MAX_VEC = 64;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] vec [0:NFIELD*MAX_VEC-1];
    logic [31:0] cmd;
    logic [31:0] rd_data;
    int          n_tests;
    int          base;

    alu_top alu_top_i (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic drive_cen();
        forever begin
            @(posedge clk);
            cen <= ($urandom % 2) == 1;     // divider steps on about half the cycles
        end
    endtask

    task automatic stop_on_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp, input logic [31:0] mask);
        if ((got & mask) !== (exp & mask)) begin
            $display("** Error: %s = 0x%h, expected 0x%h (mask 0x%h)", name, got, exp, mask);
            stop_on_failure();
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= adr;
        wb_dat_w <= data;
        do @(negedge clk); while (wb_ack !== 1'b1);   // request held until ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= adr;
        do @(negedge clk); while (wb_ack !== 1'b1);
        data = wb_dat_r;    // valid together with ack
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic run_watchdog(input int count);
        #(count * 200 * 40);
        $display("watchdog expired, the run hung after %0d cycles", count * 200);
        stop_on_failure();
    endtask

    initial begin
        void'($urandom(32'h832c50ad));
        rst      = 1'b1;
        cen      = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        for (int i = 0; i < NFIELD * MAX_VEC; i++)
            vec[i] = 32'hFFFF_FFFF;     // marks unused entries
        $readmemh("test/alu_tests.txt", vec);
        n_tests = 0;
        while (n_tests < MAX_VEC && vec[n_tests * NFIELD] != 32'hFFFF_FFFF)
            n_tests++;
        if (n_tests == 0) begin
            $display("no test vectors found in test/alu_tests.txt");
            stop_on_failure();
        end
        fork
            drive_cen();
            run_watchdog(n_tests);
        join_none
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < n_tests; t++) begin
            base = t * NFIELD;
            cmd  = '0;
            cmd[CMD_OP_MSB:CMD_OP_LSB] = vec[base][3:0];
            cmd[CMD_CX_MSB:CMD_CX_LSB] = vec[base+1][2:0];
            cmd[CMD_SZ_MSB:CMD_SZ_LSB] = vec[base+2][1:0];
            cmd[CMD_CIN]               = vec[base+3][0];
            wb_write(REG_OP0, vec[base+4]);
            wb_write(REG_OP1, vec[base+5]);
            wb_write(REG_OP2, vec[base+6]);
            wb_write(REG_CMD, cmd);     // ack arrives when the operation is done
            wb_read(REG_RESULT, rd_data);
            check_value($sformatf("vector %0d REG_RESULT", t), rd_data,
                        vec[base+7], vec[base+8]);
            wb_read(REG_FLAGS, rd_data);
            check_value($sformatf("vector %0d REG_FLAGS", t), rd_data,
                        vec[base+9], vec[base+10]);
            for (int r = 0; r < 3; r++) begin
                wb_read(REG_OP0 + r[2:0], rd_data);
                check_value($sformatf("vector %0d REG_OP%0d", t, r), rd_data,
                            vec[base+4+r], 32'hFFFF_FFFF);
            end
        end

        // result register is read only
        wb_write(REG_RESULT, ~vec[base+7]);
        wb_read(REG_RESULT, rd_data);
        check_value("REG_RESULT after write", rd_data, vec[base+7], vec[base+8]);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- test/alu_tests.txt
// op cx size cin  op0 op1 op2  result result_mask  flags flag_mask  (hex)
// flag bits: 0 C, 1 N, 2 V, 3 P, 4 H, 5 Z
0 1 0 1 0000007F 00000000 00000000 00000080 FFFFFFFF 16 3F
1 2 1 1 00001234 00001234 00000000 00000000 FFFFFFFF 28 3F
1 0 1 0 00000000 00000001 00000000 FFFFFFFF FFFFFFFF 1B 3F
0 0 2 0 7FFFFFFF 00000001 00000000 80000000 FFFFFFFF 1E 3F
0 1 2 1 FFFFFFFF 00000001 00000000 00000001 FFFFFFFF 11 3F
1 1 0 1 00000080 00000001 00000000 0000007E FFFFFFFF 1C 3F
2 3 1 0 0000F0F0 0000FF0F 00000000 0000F000 FFFFFFFF 0B 3F
3 0 0 0 12345600 00000000 00000000 12345600 FFFFFFFF 28 3F
4 1 2 1 AAAA5555 FFFF0000 00000000 55555555 FFFFFFFF 09 3F
5 0 1 0 12340F0F 00000000 00000000 0000F0F0 0000FFFF 0A 3F
6 0 2 0 0000FFFF 0000FFFF 00000000 FFFE0001 FFFFFFFF 00 14
7 0 2 0 0000FFFE 00000003 00000000 FFFFFFFA FFFFFFFF 00 14
7 0 2 0 00007FFF 00008000 00000000 C0008000 FFFFFFFF 00 14
8 0 0 0 00000064 00000007 00000000 0000020E FFFFFFFF 00 26
9 0 0 0 0000FF9C 00000007 00000000 0000FEF2 FFFFFFFF 02 26
9 0 1 0 FFFFFFF9 00000002 00000000 FFFFFFFD FFFFFFFF 02 26
9 0 1 0 00000007 0000FFFE 00000000 0001FFFD FFFFFFFF 02 26
8 0 1 0 00001234 00000000 00000000 00000000 00000000 04 04
8 0 1 0 00020000 00000001 00000000 00000000 00000000 04 04
9 0 0 0 00000080 00000001 00000000 00000000 00000000 04 04
A 3 0 0 00000000 00000000 000000C1 00000183 FFFFFFFF 03 3F
A 4 1 0 00000000 00000000 00008001 00010003 FFFFFFFF 09 3F
B 3 0 0 00000000 00000000 00000002 00000081 0000FFFF 0A 3F
B 4 1 0 00000000 00000000 00008002 0000C001 0000FFFF 02 3F
B 5 2 0 00000000 00000000 00000003 80000001 FFFFFFFF 03 3F
A 5 2 0 00000000 00000000 80000000 00000000 FFFFFFFF 29 3F
